// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_periph_shell
FILELIST := filelist.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the log holds the pass line
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
verilog/soc_pkg.sv
verilog/periph_reg_if.sv
verilog/rtc_clint.sv
verilog/irq_gateway.sv
verilog/reg_bus_router.sv
verilog/periph_shell.sv
verif/tb_periph_shell.sv

// File: verif/tb_periph_shell.sv
`timescale 1ns/1ps
`default_nettype none

module tb_periph_shell import soc_pkg::*; ();

  localparam int unsigned NumSources = 8;
  localparam int unsigned RtcDivide  = 4;
  localparam addr_t       Unmapped   = 32'h1000_0000;

  typedef enum logic [2:0] {
    OpWrite,
    OpRead,
    OpReadMin,
    OpReadHold,
    OpPulse,
    OpWait,
    OpIrq
  } op_e;

  // for OpReadHold the data field is the back-pressure length
  typedef struct packed {
    op_e   op;
    addr_t addr;
    word_t data;
    word_t exp_rdata;
    logic  exp_err;
    logic  exp_timer;
    logic  exp_ext;
  } row_t;

  logic                  clk = 1'b0;
  logic                  ndmreset_n;
  logic                  req_valid_i;
  logic                  req_ready_o;
  addr_t                 req_addr_i;
  logic                  req_write_i;
  word_t                 req_wdata_i;
  logic                  rsp_valid_o;
  logic                  rsp_ready_i;
  word_t                 rsp_rdata_o;
  logic                  rsp_error_o;
  logic [NumSources-1:0] irq_sources_i;
  logic                  timer_irq_o;
  logic                  ext_irq_o;

  row_t        rows[$];
  int unsigned cycle_cnt    = 0;
  int unsigned limit_cycles = 2000;

  periph_shell #(
    .NumSources ( NumSources ),
    .RtcDivide  ( RtcDivide  )
  ) dut0 (
    .clk           ( clk           ),
    .ndmreset_n    ( ndmreset_n    ),
    .req_valid_i   ( req_valid_i   ),
    .req_ready_o   ( req_ready_o   ),
    .req_addr_i    ( req_addr_i    ),
    .req_write_i   ( req_write_i   ),
    .req_wdata_i   ( req_wdata_i   ),
    .rsp_valid_o   ( rsp_valid_o   ),
    .rsp_ready_i   ( rsp_ready_i   ),
    .rsp_rdata_o   ( rsp_rdata_o   ),
    .rsp_error_o   ( rsp_error_o   ),
    .irq_sources_i ( irq_sources_i ),
    .timer_irq_o   ( timer_irq_o   ),
    .ext_irq_o     ( ext_irq_o     )
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= limit_cycles) begin
      $display("timeout: no progress after %0d clock cycles", limit_cycles);
      report_failure();
    end
  end

  // --------------------
  // compare tasks
  // --------------------
  task automatic report_failure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_word_min(input string name, input word_t got, input word_t min);
    if (got < min) begin
      $display("[FAIL] %s: got 0x%08h, expected at least 0x%08h", name, got, min);
      report_failure();
    end
  endtask

  task automatic check_error(input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] rsp_error_o: got 0x%0h, expected 0x%0h", got, exp);
      report_failure();
    end
  endtask

  task automatic check_irq(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      report_failure();
    end
  endtask

  // --------------------
  // bus access
  // --------------------
  // entered and left 1 ns after a rising edge
  task automatic do_access(input logic wr, input addr_t addr, input word_t data,
                           input int unsigned hold, output word_t rdata, output logic err);
    word_t       first_rdata;
    logic        first_err;
    int unsigned i;
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    req_write_i = wr;
    req_wdata_i = data;
    rsp_ready_i = (hold == 0);
    @(negedge clk);
    check_flag("req_ready_o", req_ready_o, 1'b1);
    @(posedge clk);
    #1;
    req_valid_i = 1'b0;
    for (i = 0; i < hold; i++) begin
      @(negedge clk);
      check_flag("rsp_valid_o", rsp_valid_o, 1'b1);
      check_flag("req_ready_o", req_ready_o, 1'b0);
      if (i == 0) begin
        first_rdata = rsp_rdata_o;
        first_err   = rsp_error_o;
      end else begin
        check_word("rsp_rdata_o", rsp_rdata_o, first_rdata);
        check_error(rsp_error_o, first_err);
      end
      @(posedge clk);
      #1;
    end
    rsp_ready_i = 1'b1;
    @(negedge clk);
    check_flag("rsp_valid_o", rsp_valid_o, 1'b1);
    rdata = rsp_rdata_o;
    err   = rsp_error_o;
    if (hold > 0) begin
      check_word("rsp_rdata_o", rdata, first_rdata);
      check_error(err, first_err);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic add_row(input op_e op, input addr_t addr, input word_t data,
                         input word_t exp_rdata, input logic exp_err,
                         input logic exp_timer, input logic exp_ext);
    rows.push_back('{op, addr, data, exp_rdata, exp_err, exp_timer, exp_ext});
  endtask

  task automatic build_table();
    word_t cmp_data;
    word_t en_data;
    cmp_data = $urandom() | 32'h8000_0000;
    en_data  = $urandom() & 32'h0000_00FF;
    // reset values
    add_row(OpRead, ClintBase + MtimecmpOffset, '0, 32'hFFFF_FFFF, 1'b0, 1'b0, 1'b0);
    add_row(OpRead, PlicBase + EnableOffset, '0, '0, 1'b0, 1'b0, 1'b0);
    add_row(OpRead, PlicBase + PendingOffset, '0, '0, 1'b0, 1'b0, 1'b0);
    add_row(OpRead, PlicBase + ClaimOffset, '0, '0, 1'b0, 1'b0, 1'b0);
    // readback and unmapped
    add_row(OpWrite, ClintBase + MtimecmpOffset, cmp_data, '0, 1'b0, 1'b0, 1'b0);
    add_row(OpRead, ClintBase + MtimecmpOffset, '0, cmp_data, 1'b0, 1'b0, 1'b0);
    add_row(OpWrite, PlicBase + EnableOffset, en_data, '0, 1'b0, 1'b0, 1'b0);
    add_row(OpRead, PlicBase + EnableOffset, '0, en_data, 1'b0, 1'b0, 1'b0);
    add_row(OpRead, Unmapped, '0, '0, 1'b1, 1'b0, 1'b0);
    add_row(OpRead, ClintBase + RegionLength, '0, '0, 1'b1, 1'b0, 1'b0);
    add_row(OpWrite, Unmapped, 32'h1234_5678, '0, 1'b1, 1'b0, 1'b0);
    // timer interrupt, 2*4*4+4 cycles of waiting
    add_row(OpWrite, ClintBase + MtimeOffset, '0, '0, 1'b0, 1'b0, 1'b0);
    add_row(OpWrite, ClintBase + MtimecmpOffset, 32'd3, '0, 1'b0, 1'b0, 1'b0);
    add_row(OpIrq, '0, '0, '0, 1'b0, 1'b0, 1'b0);
    add_row(OpWait, '0, 2 * RtcDivide * 4 + 4, '0, 1'b0, 1'b0, 1'b0);
    add_row(OpIrq, '0, '0, '0, 1'b0, 1'b1, 1'b0);
    add_row(OpReadMin, ClintBase + MtimeOffset, '0, 32'd3, 1'b0, 1'b1, 1'b0);
    add_row(OpWrite, ClintBase + MtimecmpOffset, 32'hFFFF_FFFF, '0, 1'b0, 1'b0, 1'b0);
    add_row(OpWait, '0, 32'd1, '0, 1'b0, 1'b0, 1'b0);
    add_row(OpIrq, '0, '0, '0, 1'b0, 1'b0, 1'b0);
    // external interrupt, sources 2 and 5 enabled
    add_row(OpWrite, PlicBase + EnableOffset, 32'h24, '0, 1'b0, 1'b0, 1'b0);
    add_row(OpRead, PlicBase + EnableOffset, '0, 32'h24, 1'b0, 1'b0, 1'b0);
    add_row(OpPulse, '0, 32'h26, '0, 1'b0, 1'b0, 1'b0);
    add_row(OpWait, '0, 32'd1, '0, 1'b0, 1'b0, 1'b0);
    add_row(OpIrq, '0, '0, '0, 1'b0, 1'b0, 1'b1);
    add_row(OpRead, PlicBase + PendingOffset, '0, 32'h26, 1'b0, 1'b0, 1'b1);
    add_row(OpRead, PlicBase + ClaimOffset, '0, 32'd3, 1'b0, 1'b0, 1'b1);
    add_row(OpRead, PlicBase + ClaimOffset, '0, 32'd6, 1'b0, 1'b0, 1'b0);
    add_row(OpRead, PlicBase + ClaimOffset, '0, 32'd0, 1'b0, 1'b0, 1'b0);
    add_row(OpIrq, '0, '0, '0, 1'b0, 1'b0, 1'b0);
    add_row(OpRead, PlicBase + PendingOffset, '0, 32'h02, 1'b0, 1'b0, 1'b0);
    // back-pressure
    add_row(OpReadHold, ClintBase + MtimecmpOffset, 1 + ($urandom() % 8),
            32'hFFFF_FFFF, 1'b0, 1'b0, 1'b0);
    add_row(OpReadHold, PlicBase + EnableOffset, 1 + ($urandom() % 8), 32'h24, 1'b0, 1'b0, 1'b0);
    add_row(OpReadHold, Unmapped, 1 + ($urandom() % 8), '0, 1'b1, 1'b0, 1'b0);
  endtask

  task automatic apply_row(input row_t r);
    word_t rdata;
    logic  err;
    case (r.op)
      OpWrite: begin
        do_access(1'b1, r.addr, r.data, 0, rdata, err);
        check_error(err, r.exp_err);
      end
      OpRead, OpReadHold: begin
        do_access(1'b0, r.addr, '0, (r.op == OpReadHold) ? r.data : 0, rdata, err);
        check_word("rsp_rdata_o", rdata, r.exp_rdata);
        check_error(err, r.exp_err);
      end
      OpReadMin: begin
        do_access(1'b0, r.addr, '0, 0, rdata, err);
        check_word_min("rsp_rdata_o", rdata, r.exp_rdata);
        check_error(err, r.exp_err);
      end
      OpPulse: begin
        irq_sources_i = r.data[NumSources-1:0];
        @(posedge clk);
        #1;
        irq_sources_i = '0;
      end
      OpWait: begin
        repeat (r.data) @(posedge clk);
        #1;
      end
      default: begin
        // irq levels only
      end
    endcase
    // interrupt levels after every access and every irq row
    if (r.op != OpPulse && r.op != OpWait) begin
      check_irq("timer_irq_o", timer_irq_o, r.exp_timer);
      check_irq("ext_irq_o", ext_irq_o, r.exp_ext);
    end
  endtask

  initial begin
    void'($urandom(85516));
    ndmreset_n    = 1'b0;
    req_valid_i   = 1'b0;
    req_addr_i    = '0;
    req_write_i   = 1'b0;
    req_wdata_i   = '0;
    rsp_ready_i   = 1'b1;
    irq_sources_i = '0;
    build_table();
    limit_cycles = 40 * rows.size() + 2000;
    repeat (3) @(posedge clk);
    #1;
    ndmreset_n = 1'b1;
    @(negedge clk);
    check_flag("req_ready_o", req_ready_o, 1'b1);
    check_flag("rsp_valid_o", rsp_valid_o, 1'b0);
    check_irq("timer_irq_o", timer_irq_o, 1'b0);
    check_irq("ext_irq_o", ext_irq_o, 1'b0);
    @(posedge clk);
    #1;
    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/irq_gateway.sv
`timescale 1ns/1ps
`default_nettype none

module irq_gateway import soc_pkg::*; #(
  parameter int unsigned NumSources = NumSourcesDefault
) (
  input  wire logic                  clk,
  input  wire logic                  ndmreset_n,
  periph_reg_if.periph               bus,
  input  wire logic [NumSources-1:0] irq_sources_i,
  output logic                       ext_irq_o
);

  logic [NumSources-1:0] src_q;
  logic [NumSources-1:0] src_rise;
  logic [NumSources-1:0] pending_q;
  logic [NumSources-1:0] enable_q;
  logic [NumSources-1:0] active;
  logic [NumSources-1:0] claim_mask;
  logic                  claim_rd;
  logic                  wr_enable;
  word_t                 claim_id;

  // --------------------
  // edge capture
  // --------------------
  assign src_rise = irq_sources_i & ~src_q;
  assign active   = pending_q & enable_q;

  assign claim_rd  = bus.sel && !bus.write && (bus.offset == ClaimOffset);
  assign wr_enable = bus.sel && bus.write && (bus.offset == EnableOffset);

  // lowest index wins, so scan from the top down
  always_comb begin
    claim_id   = '0;
    claim_mask = '0;
    for (int i = NumSources - 1; i >= 0; i--) begin
      if (active[i]) begin
        claim_id      = word_t'(i + 1);
        claim_mask    = '0;
        claim_mask[i] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      src_q     <= '0;
      pending_q <= '0;
      enable_q  <= '0;
      ext_irq_o <= 1'b0;
    end else begin
      src_q <= irq_sources_i;
      // a new edge in the claim cycle is kept
      pending_q <= (pending_q & ~(claim_rd ? claim_mask : '0)) | src_rise;
      if (wr_enable) begin
        enable_q <= bus.wdata[NumSources-1:0];
      end
      ext_irq_o <= |active;
    end
  end

  // --------------------
  // register read
  // --------------------
  always_comb begin
    unique case (bus.offset)
      PendingOffset: bus.rdata = word_t'(pending_q);
      EnableOffset:  bus.rdata = word_t'(enable_q);
      ClaimOffset:   bus.rdata = claim_id;
      default:       bus.rdata = '0;
    endcase
  end

  claim_only_enabled: assert property (
    @(posedge clk) disable iff (!ndmreset_n)
    (claim_rd && (claim_id != '0)) |-> enable_q[claim_id - 1]
  );

endmodule

`default_nettype wire

// File: verilog/periph_reg_if.sv
`timescale 1ns/1ps
`default_nettype none

// single-cycle register access, no handshake
interface periph_reg_if import soc_pkg::*; ();

  logic    sel;
  logic    write;
  offset_t offset;
  word_t   wdata;
  // combinational read data from the peripheral
  word_t   rdata;

  modport router (
    output sel,
    output write,
    output offset,
    output wdata,
    input  rdata
  );

  modport periph (
    input  sel,
    input  write,
    input  offset,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

// File: verilog/periph_shell.sv
`timescale 1ns/1ps
`default_nettype none

module periph_shell import soc_pkg::*; #(
  parameter int unsigned NumSources = NumSourcesDefault,
  parameter int unsigned RtcDivide  = RtcDivideDefault
) (
  input  wire logic                  clk,
  input  wire logic                  ndmreset_n,
  // request
  input  wire logic                  req_valid_i,
  output logic                       req_ready_o,
  input  wire addr_t                 req_addr_i,
  input  wire logic                  req_write_i,
  input  wire word_t                 req_wdata_i,
  // response
  output logic                       rsp_valid_o,
  input  wire logic                  rsp_ready_i,
  output word_t                      rsp_rdata_o,
  output logic                       rsp_error_o,
  // interrupts
  input  wire logic [NumSources-1:0] irq_sources_i,
  output logic                       timer_irq_o,
  output logic                       ext_irq_o
);

  periph_reg_if clint_if ();
  periph_reg_if plic_if ();

  reg_bus_router i_router (
    .clk         ( clk         ),
    .ndmreset_n  ( ndmreset_n  ),
    .req_valid_i ( req_valid_i ),
    .req_ready_o ( req_ready_o ),
    .req_addr_i  ( req_addr_i  ),
    .req_write_i ( req_write_i ),
    .req_wdata_i ( req_wdata_i ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_ready_i ( rsp_ready_i ),
    .rsp_rdata_o ( rsp_rdata_o ),
    .rsp_error_o ( rsp_error_o ),
    .clint_bus   ( clint_if    ),
    .plic_bus    ( plic_if     )
  );

  // --------------------
  // peripherals
  // --------------------
  rtc_clint #(
    .RtcDivide ( RtcDivide )
  ) i_clint (
    .clk         ( clk         ),
    .ndmreset_n  ( ndmreset_n  ),
    .bus         ( clint_if    ),
    .timer_irq_o ( timer_irq_o )
  );

  irq_gateway #(
    .NumSources ( NumSources )
  ) i_plic (
    .clk           ( clk           ),
    .ndmreset_n    ( ndmreset_n    ),
    .bus           ( plic_if       ),
    .irq_sources_i ( irq_sources_i ),
    .ext_irq_o     ( ext_irq_o     )
  );

endmodule

`default_nettype wire

// File: verilog/reg_bus_router.sv
`timescale 1ns/1ps
`default_nettype none

module reg_bus_router import soc_pkg::*; (
  input  wire logic    clk,
  input  wire logic    ndmreset_n,
  input  wire logic    req_valid_i,
  output logic         req_ready_o,
  input  wire addr_t   req_addr_i,
  input  wire logic    req_write_i,
  input  wire word_t   req_wdata_i,
  output logic         rsp_valid_o,
  input  wire logic    rsp_ready_i,
  output word_t        rsp_rdata_o,
  output logic         rsp_error_o,
  periph_reg_if.router clint_bus,
  periph_reg_if.router plic_bus
);

  typedef enum logic {
    RspEmpty,
    RspHeld
  } rsp_state_e;

  rsp_state_e state_q;
  rsp_state_e state_d;
  logic       req_fire;
  logic       rsp_fire;
  logic       clint_hit;
  logic       plic_hit;
  word_t      rdata_d;

  // --------------------
  // handshake
  // --------------------
  assign rsp_valid_o = (state_q == RspHeld);
  // a new request may enter while the held response leaves
  assign req_ready_o = (state_q == RspEmpty) || rsp_ready_i;
  assign req_fire    = req_valid_i && req_ready_o;
  assign rsp_fire    = rsp_valid_o && rsp_ready_i;

  always_comb begin
    state_d = state_q;
    if (rsp_fire) begin
      state_d = RspEmpty;
    end
    if (req_fire) begin
      state_d = RspHeld;
    end
  end

  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      state_q <= RspEmpty;
    end else begin
      state_q <= state_d;
    end
  end

  // --------------------
  // address decode
  // --------------------
  assign clint_hit = (req_addr_i >= ClintBase) && (req_addr_i < ClintBase + RegionLength);
  assign plic_hit  = (req_addr_i >= PlicBase) && (req_addr_i < PlicBase + RegionLength);

  assign clint_bus.sel    = req_fire && clint_hit;
  assign clint_bus.write  = req_write_i;
  assign clint_bus.offset = req_addr_i[$bits(offset_t)-1:0];
  assign clint_bus.wdata  = req_wdata_i;

  assign plic_bus.sel    = req_fire && plic_hit;
  assign plic_bus.write  = req_write_i;
  assign plic_bus.offset = req_addr_i[$bits(offset_t)-1:0];
  assign plic_bus.wdata  = req_wdata_i;

  // unmapped gives zero data
  assign rdata_d = clint_hit ? clint_bus.rdata : (plic_hit ? plic_bus.rdata : '0);

  always_ff @(posedge clk) begin
    if (req_fire) begin
      rsp_rdata_o <= rdata_d;
      rsp_error_o <= !(clint_hit || plic_hit);
    end
  end

  one_region_selected: assert property (
    @(posedge clk) disable iff (!ndmreset_n)
    !(clint_bus.sel && plic_bus.sel)
  );

endmodule

`default_nettype wire

// File: verilog/rtc_clint.sv
`timescale 1ns/1ps
`default_nettype none

module rtc_clint import soc_pkg::*; #(
  parameter int unsigned RtcDivide = RtcDivideDefault
) (
  input  wire logic     clk,
  input  wire logic     ndmreset_n,
  periph_reg_if.periph  bus,
  output logic          timer_irq_o
);

  localparam int unsigned CntWidth = $clog2(RtcDivide + 1);

  logic [CntWidth-1:0] rtc_cnt_q;
  logic                rtc_q;
  logic                rtc_dly_q;
  logic                rtc_tick;
  logic                wr_mtime;
  logic                wr_mtimecmp;
  word_t               mtime_q;
  word_t               mtimecmp_q;

  // --------------------
  // rtc divider
  // --------------------
  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_cnt_q <= '0;
      rtc_q     <= 1'b0;
      rtc_dly_q <= 1'b0;
    end else begin
      rtc_dly_q <= rtc_q;
      if (rtc_cnt_q == CntWidth'(RtcDivide - 1)) begin
        rtc_cnt_q <= '0;
        rtc_q     <= ~rtc_q;
      end else begin
        rtc_cnt_q <= rtc_cnt_q + 1'b1;
      end
    end
  end

  // high in the cycle after rtc rises
  assign rtc_tick = rtc_q & ~rtc_dly_q;

  // --------------------
  // timer registers
  // --------------------
  assign wr_mtime    = bus.sel && bus.write && (bus.offset == MtimeOffset);
  assign wr_mtimecmp = bus.sel && bus.write && (bus.offset == MtimecmpOffset);

  always_ff @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      timer_irq_o <= 1'b0;
    end else begin
      // software write wins over the rtc increment
      if (wr_mtime) begin
        mtime_q <= bus.wdata;
      end else if (rtc_tick) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (wr_mtimecmp) begin
        mtimecmp_q <= bus.wdata;
      end
      timer_irq_o <= (mtime_q >= mtimecmp_q);
    end
  end

  always_comb begin
    unique case (bus.offset)
      MtimeOffset:    bus.rdata = mtime_q;
      MtimecmpOffset: bus.rdata = mtimecmp_q;
      default:        bus.rdata = '0;
    endcase
  end

  divider_in_range: assert property (
    @(posedge clk) disable iff (!ndmreset_n)
    rtc_cnt_q < CntWidth'(RtcDivide)
  );

endmodule

`default_nettype wire

// File: verilog/soc_pkg.sv
`default_nettype none

package soc_pkg;

  // --------------------
  // widths
  // --------------------
  // bus data word, also the width of mtime and mtimecmp
  typedef logic [31:0] word_t;
  // byte address on the register bus
  typedef logic [31:0] addr_t;
  // register offset inside a region
  typedef logic [7:0]  offset_t;

  // --------------------
  // address map
  // --------------------
  localparam addr_t ClintBase    = 32'h0200_0000;
  localparam addr_t PlicBase     = 32'h0C00_0000;
  localparam addr_t RegionLength = 32'h0000_0100;

  // timer registers
  localparam offset_t MtimeOffset    = 8'h00;
  localparam offset_t MtimecmpOffset = 8'h04;

  // interrupt controller registers
  localparam offset_t PendingOffset = 8'h00;
  localparam offset_t EnableOffset  = 8'h04;
  // read returns lowest pending and enabled source as index+1
  localparam offset_t ClaimOffset   = 8'h08;

  // --------------------
  // parameter defaults
  // --------------------
  // external interrupt sources, at most one bus word
  localparam int unsigned NumSourcesDefault = 8;
  // clk cycles per half period of rtc
  localparam int unsigned RtcDivideDefault  = 50;

endpackage

`default_nettype wire
